// File: verilog/lanzones_cfg.svh
`ifndef LANZONES_CFG_SVH
`define LANZONES_CFG_SVH

`define LZ_XLEN  32
`define LZ_NREGS 32

// major opcodes, bits [6:0] of the instruction
`define LZ_OP_IMM    7'b0010011
`define LZ_OP_REG    7'b0110011
`define LZ_OP_LUI    7'b0110111
`define LZ_OP_JAL    7'b1101111
`define LZ_OP_BRANCH 7'b1100011
`define LZ_OP_LOAD   7'b0000011
`define LZ_OP_STORE  7'b0100011
`define LZ_OP_HALT   7'h7F

`endif

// File: verilog/lanzonesPkg.sv
`include "lanzones_cfg.svh"

package lanzonesPkg;

   typedef logic [`LZ_XLEN-1:0] word_t;
   typedef logic [4:0]          regIdx_t;
   typedef logic [31:0]         addr_t;    // word index, not byte address

   typedef enum logic [4:0] {
      OP_NONE,
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT,
      OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI,
      OP_LUI, OP_JAL,
      OP_BEQ, OP_BNE, OP_BLT, OP_BGE,
      OP_LW, OP_SW
   } aluOp_t;

   typedef enum logic [1:0] {S_HALT, S_FETCH, S_EXEC, S_MEMWAIT} seqState_t;

   typedef struct packed {
      addr_t addr;
      word_t wData;
      logic  wEn;
   } busReq_t;

   typedef struct packed {
      aluOp_t  op;
      regIdx_t rd;
      regIdx_t rs1;
      regIdx_t rs2;
      word_t   imm;       // already sign-extended
      logic    isLoad;
      logic    isStore;
      logic    isBranch;
      logic    writesRd;
      logic    invalid;
      logic    isHalt;
   } decoded_t;

endpackage

// File: verilog/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit (
   input  logic                  clk,
   input  logic                  rstn,
   input  logic                  lEn,
   input  logic                  fetchDone,
   input  lanzonesPkg::word_t    busRData,
   input  lanzonesPkg::decoded_t dec,
   input  lanzonesPkg::word_t    aluResult,
   input  logic                  branchTaken,
   input  logic                  lsuBusy,
   output logic                  fetchReqValid,
   output lanzonesPkg::busReq_t  fetchReq,
   output lanzonesPkg::word_t    instr,
   output logic                  halt,
   output logic                  startMem,
   output logic                  wbEn,
   output lanzonesPkg::regIdx_t  wbIdx,
   output lanzonesPkg::word_t    wbData
);

   lanzonesPkg::seqState_t state;
   lanzonesPkg::addr_t     pc;
   logic                   stop;
   logic                   takeJump;
   logic                   inExec;

   assign inExec   = (state == lanzonesPkg::S_EXEC);
   assign stop     = dec.isHalt || dec.invalid;
   assign takeJump = (dec.isBranch && branchTaken) || (dec.op == lanzonesPkg::OP_JAL);
   assign startMem = inExec;

   assign fetchReq.addr  = pc;
   assign fetchReq.wData = '0;
   assign fetchReq.wEn   = 1'b0;

   // loads write back through the lsu instead
   assign wbEn   = inExec && dec.writesRd && !dec.isLoad;
   assign wbIdx  = dec.rd;
   assign wbData = (dec.op == lanzonesPkg::OP_JAL) ? pc + 32'd1 : aluResult;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state         <= lanzonesPkg::S_HALT;
         halt          <= 1'b1;
         fetchReqValid <= 1'b0;
         pc            <= '0;
      end
      else begin
         case (state)
            lanzonesPkg::S_HALT: begin
               if (lEn) begin
                  state         <= lanzonesPkg::S_FETCH;
                  halt          <= 1'b0;
                  fetchReqValid <= 1'b1;
               end
            end
            lanzonesPkg::S_FETCH: begin
               if (fetchDone) begin
                  fetchReqValid <= 1'b0;
                  state         <= lanzonesPkg::S_EXEC;
               end
            end
            lanzonesPkg::S_EXEC: begin
               pc <= takeJump ? dec.imm : pc + 32'd1;   // restart resumes after a halt
               if (stop) begin
                  halt  <= 1'b1;
                  state <= lanzonesPkg::S_HALT;
               end
               else begin
                  fetchReqValid <= 1'b1;
                  state <= (dec.isLoad || dec.isStore) ? lanzonesPkg::S_MEMWAIT
                                                       : lanzonesPkg::S_FETCH;
               end
            end
            lanzonesPkg::S_MEMWAIT: begin
               // next fetch overlaps the data access, arbiter serves data first
               if (fetchDone) begin
                  fetchReqValid <= 1'b0;
               end
               if (!lsuBusy && (fetchDone || !fetchReqValid)) begin
                  state <= lanzonesPkg::S_EXEC;
               end
            end
            default: state <= lanzonesPkg::S_HALT;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (fetchDone) begin
         instr <= busRData;
      end
   end

endmodule

// File: verilog/decoder.sv
`timescale 1ns/1ps
`include "lanzones_cfg.svh"

module decoder (
   input  lanzonesPkg::word_t    instr,
   output lanzonesPkg::decoded_t dec
);

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;

   assign opcode = instr[6:0];
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];

   always_comb begin
      dec     = '0;
      dec.op  = lanzonesPkg::OP_NONE;
      dec.rd  = instr[11:7];
      dec.rs1 = instr[19:15];
      dec.rs2 = instr[24:20];
      case (opcode)
         `LZ_OP_IMM: begin
            dec.imm      = {{(`LZ_XLEN-12){instr[31]}}, instr[31:20]};
            dec.writesRd = 1'b1;
            case (funct3)
               3'b000:  dec.op = lanzonesPkg::OP_ADDI;
               3'b010:  dec.op = lanzonesPkg::OP_SLTI;
               3'b100:  dec.op = lanzonesPkg::OP_XORI;
               3'b110:  dec.op = lanzonesPkg::OP_ORI;
               3'b111:  dec.op = lanzonesPkg::OP_ANDI;
               default: dec.invalid = 1'b1;   // shifts and sltiu
            endcase
         end
         `LZ_OP_REG: begin
            dec.writesRd = 1'b1;
            if (funct7 == 7'b0000000) begin
               case (funct3)
                  3'b000:  dec.op = lanzonesPkg::OP_ADD;
                  3'b010:  dec.op = lanzonesPkg::OP_SLT;
                  3'b100:  dec.op = lanzonesPkg::OP_XOR;
                  3'b110:  dec.op = lanzonesPkg::OP_OR;
                  3'b111:  dec.op = lanzonesPkg::OP_AND;
                  default: dec.invalid = 1'b1;
               endcase
            end
            else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
               dec.op = lanzonesPkg::OP_SUB;
            end
            else begin
               dec.invalid = 1'b1;
            end
         end
         `LZ_OP_LUI: begin
            dec.op       = lanzonesPkg::OP_LUI;
            dec.imm      = {instr[31:12], 12'h000};
            dec.writesRd = 1'b1;
         end
         `LZ_OP_JAL: begin
            // target is an absolute word index
            dec.op       = lanzonesPkg::OP_JAL;
            dec.imm      = {{(`LZ_XLEN-20){instr[31]}}, instr[31:12]};
            dec.writesRd = 1'b1;
         end
         `LZ_OP_BRANCH: begin
            dec.imm      = {{(`LZ_XLEN-12){instr[31]}}, funct7, instr[11:7]};
            dec.isBranch = 1'b1;
            case (funct3)
               3'b000:  dec.op = lanzonesPkg::OP_BEQ;
               3'b001:  dec.op = lanzonesPkg::OP_BNE;
               3'b100:  dec.op = lanzonesPkg::OP_BLT;
               3'b101:  dec.op = lanzonesPkg::OP_BGE;
               default: dec.invalid = 1'b1;
            endcase
         end
         `LZ_OP_LOAD: begin
            dec.op       = lanzonesPkg::OP_LW;
            dec.imm      = {{(`LZ_XLEN-12){instr[31]}}, instr[31:20]};
            dec.isLoad   = 1'b1;
            dec.writesRd = 1'b1;
            dec.invalid  = (funct3 != 3'b010);   // word only
         end
         `LZ_OP_STORE: begin
            dec.op      = lanzonesPkg::OP_SW;
            dec.imm     = {{(`LZ_XLEN-12){instr[31]}}, funct7, instr[11:7]};
            dec.isStore = 1'b1;
            dec.invalid = (funct3 != 3'b010);
         end
         `LZ_OP_HALT: dec.isHalt = 1'b1;
         default:     dec.invalid = 1'b1;
      endcase
      // an invalid word must not touch registers or memory
      if (dec.invalid) begin
         dec.writesRd = 1'b0;
         dec.isLoad   = 1'b0;
         dec.isStore  = 1'b0;
         dec.isBranch = 1'b0;
         dec.op       = lanzonesPkg::OP_NONE;
      end
   end

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ps

module alu (
   input  lanzonesPkg::decoded_t dec,
   input  lanzonesPkg::word_t    rs1Data,
   input  lanzonesPkg::word_t    rs2Data,
   output lanzonesPkg::word_t    aluResult,
   output logic                  branchTaken
);

   lanzonesPkg::word_t sum;
   logic               lt;
   logic               ltImm;

   assign sum   = rs1Data + dec.imm;   // addi and load/store address
   assign lt    = $signed(rs1Data) < $signed(rs2Data);
   assign ltImm = $signed(rs1Data) < $signed(dec.imm);

   always_comb begin
      aluResult   = '0;
      branchTaken = 1'b0;
      case (dec.op)
         lanzonesPkg::OP_ADD:  aluResult = rs1Data + rs2Data;
         lanzonesPkg::OP_SUB:  aluResult = rs1Data - rs2Data;
         lanzonesPkg::OP_AND:  aluResult = rs1Data & rs2Data;
         lanzonesPkg::OP_OR:   aluResult = rs1Data | rs2Data;
         lanzonesPkg::OP_XOR:  aluResult = rs1Data ^ rs2Data;
         lanzonesPkg::OP_SLT:  aluResult = {{31{1'b0}}, lt};
         lanzonesPkg::OP_ADDI: aluResult = sum;
         lanzonesPkg::OP_LW:   aluResult = sum;
         lanzonesPkg::OP_SW:   aluResult = sum;
         lanzonesPkg::OP_ANDI: aluResult = rs1Data & dec.imm;
         lanzonesPkg::OP_ORI:  aluResult = rs1Data | dec.imm;
         lanzonesPkg::OP_XORI: aluResult = rs1Data ^ dec.imm;
         lanzonesPkg::OP_SLTI: aluResult = {{31{1'b0}}, ltImm};
         lanzonesPkg::OP_LUI:  aluResult = dec.imm;
         lanzonesPkg::OP_BEQ:  branchTaken = (rs1Data == rs2Data);
         lanzonesPkg::OP_BNE:  branchTaken = (rs1Data != rs2Data);
         lanzonesPkg::OP_BLT:  branchTaken = lt;
         lanzonesPkg::OP_BGE:  branchTaken = !lt;
         default:              aluResult = '0;   // jal link comes from fetch
      endcase
   end

endmodule

// File: verilog/regFile.sv
`timescale 1ns/1ps
`include "lanzones_cfg.svh"

module regFile (
   input  logic                       clk,
   input  logic                       rstn,
   input  lanzonesPkg::regIdx_t       rs1,
   input  lanzonesPkg::regIdx_t       rs2,
   input  logic [1:0]                 wEn,    // [0] fetch writeback, [1] load
   input  lanzonesPkg::regIdx_t [1:0] wIdx,
   input  lanzonesPkg::word_t [1:0]   wData,
   output lanzonesPkg::word_t         rs1Data,
   output lanzonesPkg::word_t         rs2Data
);

   lanzonesPkg::word_t regs [`LZ_NREGS];

   // x0 is never written and reads zero
   assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
   assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < `LZ_NREGS; i++) begin
            regs[i] <= '0;
         end
      end
      else begin
         // sources never write in the same cycle
         for (int p = 0; p < 2; p++) begin
            if (wEn[p] && wIdx[p] != '0) begin
               regs[wIdx[p]] <= wData[p];
            end
         end
      end
   end

endmodule

// File: verilog/loadStoreUnit.sv
`timescale 1ns/1ps

module loadStoreUnit (
   input  logic                  clk,
   input  logic                  rstn,
   input  logic                  startMem,
   input  lanzonesPkg::decoded_t dec,
   input  lanzonesPkg::word_t    aluResult,
   input  lanzonesPkg::word_t    rs2Data,
   input  logic                  lsuDone,
   input  lanzonesPkg::word_t    busRData,
   output logic                  lsuReqValid,
   output lanzonesPkg::busReq_t  lsuReq,
   output logic                  lsuBusy,
   output logic                  ldWEn,
   output lanzonesPkg::regIdx_t  ldIdx,
   output lanzonesPkg::word_t    ldData
);

   logic memOp;
   logic ldPend;

   assign memOp   = startMem && (dec.isLoad || dec.isStore);
   assign lsuBusy = lsuReqValid || ldWEn;   // covers the load writeback cycle

   always_ff @(posedge clk) begin
      if (!rstn) begin
         lsuReqValid <= 1'b0;
         ldPend      <= 1'b0;
         ldWEn       <= 1'b0;
      end
      else begin
         ldWEn <= 1'b0;
         if (memOp) begin
            lsuReqValid <= 1'b1;
            ldPend      <= dec.isLoad;
         end
         else if (lsuDone) begin
            lsuReqValid <= 1'b0;
            ldPend      <= 1'b0;
            ldWEn       <= ldPend;   // write rd one cycle after done
         end
      end
   end

   always_ff @(posedge clk) begin
      if (memOp) begin
         lsuReq.addr  <= aluResult;
         lsuReq.wData <= rs2Data;
         lsuReq.wEn   <= dec.isStore;
         ldIdx        <= dec.rd;
      end
      if (lsuDone) begin
         ldData <= busRData;
      end
   end

endmodule

// File: verilog/busArbiter.sv
`timescale 1ns/1ps

module busArbiter (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 fetchReqValid,
   input  lanzonesPkg::busReq_t fetchReq,
   input  logic                 lsuReqValid,
   input  lanzonesPkg::busReq_t lsuReq,
   input  logic                 rVld,
   output logic                 rRdy,
   output lanzonesPkg::busReq_t rReq,
   output logic                 fetchDone,
   output logic                 lsuDone
);

   logic ownLsu;   // grant owner, held while rRdy is up
   logic xfer;

   assign xfer      = rRdy && rVld;
   assign lsuDone   = xfer && ownLsu;
   assign fetchDone = xfer && !ownLsu;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         rRdy   <= 1'b0;
         ownLsu <= 1'b0;
         rReq   <= '0;
      end
      else if (xfer) begin
         rRdy <= 1'b0;   // one idle cycle after every transfer
      end
      else if (!rRdy) begin
         if (lsuReqValid) begin
            rRdy   <= 1'b1;
            ownLsu <= 1'b1;
            rReq   <= lsuReq;
         end
         else if (fetchReqValid) begin
            rRdy   <= 1'b1;
            ownLsu <= 1'b0;
            rReq   <= fetchReq;
         end
      end
   end

endmodule

// File: verilog/lanzonesTop.sv
`timescale 1ns/1ps

module lanzonesTop (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 lEn,
   input  logic                 rVld,
   input  lanzonesPkg::word_t   rData,
   output logic                 rRdy,
   output lanzonesPkg::busReq_t rReq,
   output logic                 halt
);

   lanzonesPkg::decoded_t dec;
   lanzonesPkg::word_t    instr;
   lanzonesPkg::word_t    aluResult;
   lanzonesPkg::word_t    rs1Data;
   lanzonesPkg::word_t    rs2Data;
   lanzonesPkg::word_t    wbData;
   lanzonesPkg::word_t    ldData;
   lanzonesPkg::regIdx_t  wbIdx;
   lanzonesPkg::regIdx_t  ldIdx;
   lanzonesPkg::busReq_t  fetchReq;
   lanzonesPkg::busReq_t  lsuReq;
   logic                  fetchReqValid;
   logic                  lsuReqValid;
   logic                  fetchDone;
   logic                  lsuDone;
   logic                  branchTaken;
   logic                  lsuBusy;
   logic                  startMem;
   logic                  wbEn;
   logic                  ldWEn;

   fetchUnit uFetch (
      .clk, .rstn, .lEn, .fetchDone, .busRData(rData), .dec, .aluResult,
      .branchTaken, .lsuBusy, .fetchReqValid, .fetchReq, .instr, .halt,
      .startMem, .wbEn, .wbIdx, .wbData
   );

   decoder uDec (.instr, .dec);

   alu uAlu (.dec, .rs1Data, .rs2Data, .aluResult, .branchTaken);

   regFile uRegs (
      .clk, .rstn, .rs1(dec.rs1), .rs2(dec.rs2),
      .wEn({ldWEn, wbEn}), .wIdx({ldIdx, wbIdx}), .wData({ldData, wbData}),
      .rs1Data, .rs2Data
   );

   loadStoreUnit uLsu (
      .clk, .rstn, .startMem, .dec, .aluResult, .rs2Data, .lsuDone,
      .busRData(rData), .lsuReqValid, .lsuReq, .lsuBusy, .ldWEn, .ldIdx, .ldData
   );

   busArbiter uArb (
      .clk, .rstn, .fetchReqValid, .fetchReq, .lsuReqValid, .lsuReq, .rVld,
      .rRdy, .rReq, .fetchDone, .lsuDone
   );

endmodule

// File: tests/lanzones_asserts.sv
`timescale 1ns/1ps

module lanzones_asserts (
   input logic                 clk,
   input logic                 rstn,
   input logic                 lEn,
   input logic                 rVld,
   input logic                 rRdy,
   input lanzonesPkg::busReq_t rReq,
   input logic                 halt
);

   int failCount = 0;

   resetIdle: assert property (@(posedge clk) !rstn |=> !rRdy && !rReq.wEn && halt)
      else begin failCount++; $error("bus not idle or core not halted after reset"); end

   // halted core waits for lEn
   haltHold: assert property (@(posedge clk) disable iff (!rstn) halt && !lEn |=> halt)
      else begin failCount++; $error("halt dropped without lEn"); end

   haltQuiet: assert property (@(posedge clk) disable iff (!rstn) halt |-> !rRdy && !rReq.wEn)
      else begin failCount++; $error("bus request or write raised while halted"); end

   reqStable: assert property (@(posedge clk) disable iff (!rstn)
      rRdy && !rVld |=> rRdy && $stable(rReq))
      else begin failCount++; $error("request changed or dropped before transfer"); end

   // one idle cycle after every transfer
   dropAfterXfer: assert property (@(posedge clk) disable iff (!rstn) rRdy && rVld |=> !rRdy)
      else begin failCount++; $error("rRdy still high after transfer"); end

endmodule

bind lanzonesTop lanzones_asserts chk (
   .clk(clk), .rstn(rstn), .lEn(lEn), .rVld(rVld), .rRdy(rRdy), .rReq(rReq), .halt(halt)
);

// File: tests/lanzonesTb.sv
`timescale 1ns/1ps
`include "lanzones_cfg.svh"

module lanzonesTb;

   localparam int dataBase  = 'h100;
   localparam int markBase  = 'h120;
   localparam int loadSrc   = 'h1C0;
   localparam int wrongAddr = 'h1F0;   // only a wrong path stores here

   logic                 clk = 1'b0;
   logic                 rstn;
   logic                 lEn;
   logic                 rVld = 1'b0;
   lanzonesPkg::word_t   rData = '0;
   logic                 rRdy;
   lanzonesPkg::busReq_t rReq;
   logic                 halt;

   logic [31:0] mem [512];
   logic [31:0] expAddr [64];
   logic [31:0] expData [64];
   int          expCount;
   int          phase1Count;
   int          seen;
   int          pc;
   int          markCount;
   logic [31:0] rngState;
   logic [1:0]  delay;
   logic        dataNext;
   logic [6:0]  lastOp;

   lanzonesTop UUT (.clk, .rstn, .lEn, .rVld, .rData, .rRdy, .rReq, .halt);

   always #4 clk = ~clk;

   task automatic abortRun(string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1, "run stopped on first error");
   endtask

   task automatic valueFail(string sig, logic [31:0] got, logic [31:0] exp);
      abortRun($sformatf("[FAIL] %s got %h expected %h", sig, got, exp));
   endtask

   function automatic logic [31:0] xorshift(logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] immInstr(logic [6:0] op, logic [2:0] f3, int rd, int rs1,
                                            int imm);
      return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
   endfunction

   function automatic logic [31:0] regInstr(logic [6:0] f7, logic [2:0] f3, int rd, int rs1,
                                            int rs2);
      return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], `LZ_OP_REG};
   endfunction

   function automatic logic [31:0] storeInstr(int rs1, int rs2, int imm);
      return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], `LZ_OP_STORE};
   endfunction

   // branch and jal targets are absolute word indices
   function automatic logic [31:0] branchInstr(logic [2:0] f3, int rs1, int rs2, int target);
      return {target[11:5], rs2[4:0], rs1[4:0], f3, target[4:0], `LZ_OP_BRANCH};
   endfunction

   function automatic logic [31:0] luiInstr(int rd, int upper);
      return {upper[19:0], rd[4:0], `LZ_OP_LUI};
   endfunction

   function automatic logic [31:0] jalInstr(int rd, int target);
      return {target[19:0], rd[4:0], `LZ_OP_JAL};
   endfunction

   task automatic emit(logic [31:0] w);
      mem[pc[8:0]] = w;
      pc++;
   endtask

   task automatic storeChecked(int rs2, int addr, logic [31:0] data);
      emit(storeInstr(0, rs2, addr));
      expAddr[expCount[5:0]] = addr;
      expData[expCount[5:0]] = data;
      expCount++;
   endtask

   // marker store lands only on the predicted path
   task automatic branchCase(logic [2:0] f3, int rsA, int rsB, logic [31:0] va,
                             logic [31:0] vb);
      logic taken;
      case (f3)
         3'b000:  taken = (va == vb);
         3'b001:  taken = (va != vb);
         3'b100:  taken = ($signed(va) < $signed(vb));
         default: taken = ($signed(va) >= $signed(vb));
      endcase
      emit(branchInstr(f3, rsA, rsB, pc + 2));
      if (taken) begin
         emit(storeInstr(0, 9, wrongAddr));
      end
      storeChecked(9, markBase + markCount, 32'h5A);
      markCount++;
   endtask

   task automatic buildProgram();
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] u;
      int          jalAt;
      a = 32'd25;
      b = 32'd0 - 32'd7;
      u = 32'h12345000;
      for (int i = 0; i < 512; i++) begin
         mem[i[8:0]] = 32'h5A000000 ^ i[31:0] ^ (i[31:0] << 16);
      end
      mem[loadSrc[8:0]] = 32'hCAFE0001;
      pc = 0;
      expCount = 0;
      markCount = 0;
      emit(immInstr(`LZ_OP_IMM, 3'b000, 1, 0, 25));
      emit(immInstr(`LZ_OP_IMM, 3'b000, 2, 0, -7));
      emit(immInstr(`LZ_OP_IMM, 3'b000, 9, 0, 'h5A));   // marker value
      storeChecked(1, dataBase + 0, a);
      storeChecked(2, dataBase + 1, b);
      emit(regInstr(7'h00, 3'b000, 3, 1, 2));
      storeChecked(3, dataBase + 2, a + b);
      emit(regInstr(7'h20, 3'b000, 3, 1, 2));
      storeChecked(3, dataBase + 3, a - b);
      emit(regInstr(7'h00, 3'b111, 3, 1, 2));
      storeChecked(3, dataBase + 4, a & b);
      emit(regInstr(7'h00, 3'b110, 3, 1, 2));
      storeChecked(3, dataBase + 5, a | b);
      emit(regInstr(7'h00, 3'b100, 3, 1, 2));
      storeChecked(3, dataBase + 6, a ^ b);
      emit(regInstr(7'h00, 3'b010, 3, 2, 1));
      storeChecked(3, dataBase + 7, {31'd0, ($signed(b) < $signed(a))});
      emit(immInstr(`LZ_OP_IMM, 3'b010, 3, 1, -3));
      storeChecked(3, dataBase + 8, {31'd0, ($signed(a) < -32'sd3)});
      emit(luiInstr(4, 'h12345));
      storeChecked(4, dataBase + 9, u);
      emit(immInstr(`LZ_OP_IMM, 3'b110, 5, 4, 'h7A5));
      storeChecked(5, dataBase + 10, u | 32'h7A5);
      emit(immInstr(`LZ_OP_IMM, 3'b111, 3, 5, 'h0F0));
      storeChecked(3, dataBase + 11, (u | 32'h7A5) & 32'h0F0);
      emit(immInstr(`LZ_OP_IMM, 3'b100, 3, 5, -1));
      storeChecked(3, dataBase + 12, ~(u | 32'h7A5));
      emit(immInstr(`LZ_OP_LOAD, 3'b010, 6, 0, loadSrc));
      storeChecked(6, dataBase + 13, 32'hCAFE0001);   // load then store at once
      emit(immInstr(`LZ_OP_IMM, 3'b000, 7, 6, 100));
      storeChecked(7, dataBase + 14, 32'hCAFE0001 + 32'd100);
      branchCase(3'b000, 1, 1, a, a);
      branchCase(3'b000, 1, 2, a, b);
      branchCase(3'b001, 1, 2, a, b);
      branchCase(3'b001, 1, 1, a, a);
      branchCase(3'b100, 2, 1, b, a);
      branchCase(3'b100, 1, 2, a, b);
      branchCase(3'b101, 1, 2, a, b);
      branchCase(3'b101, 2, 1, b, a);
      jalAt = pc;
      emit(jalInstr(10, pc + 2));
      emit(storeInstr(0, 9, wrongAddr));
      storeChecked(10, dataBase + 15, jalAt + 1);   // link value
      emit({25'd0, `LZ_OP_HALT});
      phase1Count = expCount;
      // restart resumes right after the halt word
      storeChecked(9, dataBase + 16, 32'h5A);
      emit(immInstr(`LZ_OP_IMM, 3'b001, 3, 1, 1));   // shift, not in the set
   endtask

   // memory model, random 0..3 cycle answer delay
   always @(posedge clk) begin
      if (!rstn) begin
         rVld     <= 1'b0;
         seen     <= 0;
         rngState <= 32'd66;
         delay    <= 2'd0;
         dataNext <= 1'b0;
         lastOp   <= '0;
      end
      else if (rRdy && rVld) begin
         rVld     <= 1'b0;
         rngState <= xorshift(rngState);
         delay    <= rngState[1:0];
         if (dataNext) begin
            // data access of a load or store goes ahead of the next fetch
            if (lastOp == `LZ_OP_STORE) begin
               assert (rReq.wEn) else abortRun("fetch served before the pending store");
            end
            else begin
               assert (!rReq.wEn && rReq.addr == loadSrc)
                  else abortRun("fetch served before the pending load");
            end
            dataNext <= 1'b0;
         end
         else begin
            lastOp   <= rData[6:0];
            dataNext <= (rData[6:0] == `LZ_OP_LOAD) || (rData[6:0] == `LZ_OP_STORE);
         end
         if (rReq.wEn) begin
            assert (seen < expCount) else abortRun("store seen after all expected stores");
            assert (rReq.addr == expAddr[seen[5:0]])
               else valueFail("rReq.addr", rReq.addr, expAddr[seen[5:0]]);
            assert (rReq.wData == expData[seen[5:0]])
               else valueFail("rReq.wData", rReq.wData, expData[seen[5:0]]);
            seen <= seen + 1;
         end
      end
      else if (rRdy) begin
         assert (rReq.addr < 32'd512) else abortRun("bus address outside the memory");
         if (delay == 2'd0) begin
            rVld  <= 1'b1;
            rData <= mem[rReq.addr[8:0]];
         end
         else begin
            delay <= delay - 2'd1;
         end
      end
   end

   always @(posedge clk) begin
      assert (UUT.chk.failCount == 0) else abortRun("a bound bus or halt assertion failed");
   end

   task automatic waitHalt(logic level, int limit);
      int n;
      n = 0;
      while (halt !== level) begin
         @(posedge clk);
         n++;
         if (n > limit) begin
            abortRun($sformatf("timed out waiting for halt to become %0d", level));
         end
      end
   endtask

   task automatic pulseStart();
      @(posedge clk);
      lEn <= 1'b1;
      @(posedge clk);
      lEn <= 1'b0;
   endtask

   initial begin
      rstn = 1'b0;
      lEn  = 1'b0;
      buildProgram();
      repeat (5) @(posedge clk);
      rstn <= 1'b1;
      repeat (4) @(posedge clk);   // idle while halted
      pulseStart();
      waitHalt(1'b0, 20);
      waitHalt(1'b1, 5000);
      assert (seen == phase1Count) else abortRun("stores before the halt word are missing");
      repeat (10) @(posedge clk);
      pulseStart();
      waitHalt(1'b0, 20);
      waitHalt(1'b1, 500);
      assert (seen == expCount) else abortRun("store after restart is missing");
      repeat (10) @(posedge clk);
      if (UUT.chk.failCount != 0) begin
         abortRun("a bound bus or halt assertion failed");
      end
      else begin
         $display("Simulation passed");
         $finish;
      end
   end

endmodule

// File: list.f
+incdir+verilog
verilog/lanzonesPkg.sv
verilog/fetchUnit.sv
verilog/decoder.sv
verilog/alu.sv
verilog/regFile.sv
verilog/loadStoreUnit.sv
verilog/busArbiter.sv
verilog/lanzonesTop.sv
tests/lanzones_asserts.sv
tests/lanzonesTb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = lanzonesTb
FILELIST = list.f
OBJDIR   = obj_dir
# let the testbench see bound assertion errors before the run ends
RUNARGS  = +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) $(RUNARGS)

clean:
	rm -rf $(OBJDIR)
